// ==== ioPkg.sv ====
package ioPkg;

  // Bus word used for both addresses and data
  typedef logic [31:0] wordT;

  // One access as presented by the bus master
  typedef struct packed {
    wordT addr;
    wordT data;
    logic write;
  } busReqT;

  // Seven-segment digit, segments g..a, active low
  typedef logic [6:0] segT;

  // Six digits, digit 5 is the leftmost
  typedef segT [5:0] hexOutT;

  // Memory-mapped register addresses
  localparam wordT addrHex      = 32'hFFFF_F000;
  localparam wordT addrLedr     = 32'hFFFF_F020;
  localparam wordT addrKeyData  = 32'hFFFF_F080;
  localparam wordT addrKeyCtrl  = 32'hFFFF_F084;
  localparam wordT addrSwData   = 32'hFFFF_F090;
  localparam wordT addrSwCtrl   = 32'hFFFF_F094;
  localparam wordT addrTimerCnt = 32'hFFFF_F100;
  localparam wordT addrTimerLim = 32'hFFFF_F104;
  localparam wordT addrTimerCtl = 32'hFFFF_F108;

  // Flag positions shared by every status and control register
  localparam int readyBit   = 0;
  localparam int overrunBit = 1;

  // Stored widths of the display registers
  localparam int hexBits = 24;
  localparam int ledBits = 10;

  // Digits shown right after reset
  localparam logic [hexBits-1:0] hexResetValue = 24'h123456;

  // Raw input widths
  localparam int keyCount    = 4;
  localparam int switchCount = 10;

  // Cycles an input must hold still before it is taken
  localparam int debounceCycles = 16;

  // Clock cycles per timer tick, kept short for simulation
  localparam int timerTickDiv = 8;

endpackage

// ==== ioBus.sv ====
`timescale 1ns/1ns

module ioBus (
  input  logic          clk,
  input  logic          reset,
  input  logic          req,
  input  ioPkg::busReqT busReq,
  output logic          ack,
  output ioPkg::wordT   rdData,
  output logic          accWrite,
  output ioPkg::wordT   accData,
  output logic          hexSel,
  output logic          ledSel,
  output logic          keySel,
  output logic          swSel,
  output logic          timerSel,
  output logic [1:0]    regSel,
  input  ioPkg::wordT   hexRd,
  input  ioPkg::wordT   ledRd,
  input  ioPkg::wordT   keyRd,
  input  ioPkg::wordT   swRd,
  input  ioPkg::wordT   timerRd
);

  // Four-phase handshake: take request, ack, wait for req low, drop ack
  typedef enum logic [1:0] {stIdle, stAccess, stAcked, stDrop} stateT;

  stateT         state;
  ioPkg::busReqT reqQ;
  ioPkg::wordT   rdMux;
  logic          active;
  logic          hitHex;
  logic          hitLed;
  logic          hitKey;
  logic          hitSw;
  logic          hitTimer;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= stIdle;
      ack   <= 1'b0;
    end else begin
      case (state)
        stIdle: begin
          if (req) state <= stAccess;
        end
        stAccess: begin
          state <= stAcked;
          ack   <= 1'b1;
        end
        // A req held high here causes no second access
        stAcked: begin
          if (!req) state <= stDrop;
        end
        stDrop: begin
          state <= stIdle;
          ack   <= 1'b0;
        end
        default: state <= stIdle;
      endcase
    end
  end

  // Latch the request when it is first seen, capture read data on ack
  always_ff @(posedge clk) begin
    if (state == stIdle && req) reqQ <= busReq;
    if (state == stAccess) rdData <= rdMux;
  end

  // Address decode
  assign hitHex   = (reqQ.addr == ioPkg::addrHex);
  assign hitLed   = (reqQ.addr == ioPkg::addrLedr);
  assign hitKey   = (reqQ.addr == ioPkg::addrKeyData) || (reqQ.addr == ioPkg::addrKeyCtrl);
  assign hitSw    = (reqQ.addr == ioPkg::addrSwData) || (reqQ.addr == ioPkg::addrSwCtrl);
  assign hitTimer = (reqQ.addr == ioPkg::addrTimerCnt) || (reqQ.addr == ioPkg::addrTimerLim) ||
                    (reqQ.addr == ioPkg::addrTimerCtl);

  // Strobes last exactly the one access cycle
  assign active   = (state == stAccess);
  assign hexSel   = active && hitHex;
  assign ledSel   = active && hitLed;
  assign keySel   = active && hitKey;
  assign swSel    = active && hitSw;
  assign timerSel = active && hitTimer;

  // Word offset inside a device
  assign regSel   = reqQ.addr[3:2];
  assign accWrite = reqQ.write;
  assign accData  = reqQ.data;

  always_comb begin
    if (hitHex)        rdMux = hexRd;
    else if (hitLed)   rdMux = ledRd;
    else if (hitKey)   rdMux = keyRd;
    else if (hitSw)    rdMux = swRd;
    else if (hitTimer) rdMux = timerRd;
    else               rdMux = '0;
  end

endmodule

// ==== inputPort.sv ====
`timescale 1ns/1ns

module inputPort #(
  parameter type rawT = logic [ioPkg::keyCount-1:0]
) (
  input  logic        clk,
  input  logic        reset,
  input  rawT         raw,
  input  logic        strobe,
  input  logic        write,
  input  logic [1:0]  regSel,
  input  ioPkg::wordT wrData,
  output ioPkg::wordT rdData
);

  rawT  lastRaw;
  rawT  dataQ;
  logic [$clog2(ioPkg::debounceCycles+1)-1:0] stableCnt;
  logic ready;
  logic overrun;
  logic stable;
  logic accept;
  logic dataRead;
  logic clrOverrun;

  assign stable = (stableCnt == ioPkg::debounceCycles);

  // A settled value that differs from the stored one is taken
  assign accept = stable && (lastRaw != dataQ);

  assign dataRead   = strobe && !write && (regSel == 2'd0);
  assign clrOverrun = strobe && write && (regSel == 2'd1) && !wrData[ioPkg::overrunBit];

  // Stability counter restarts on every raw change and saturates
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lastRaw   <= '0;
      stableCnt <= '0;
    end else if (raw != lastRaw) begin
      lastRaw   <= raw;
      stableCnt <= '0;
    end else if (!stable) begin
      stableCnt <= stableCnt + 1'b1;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dataQ   <= '0;
      ready   <= 1'b0;
      overrun <= 1'b0;
    end else begin
      if (clrOverrun) overrun <= 1'b0;
      if (accept) begin
        dataQ <= lastRaw;
        // New value while the last one is still unread
        if (ready && !dataRead) overrun <= 1'b1;
        ready <= 1'b1;
      end else if (dataRead) begin
        ready <= 1'b0;
      end
    end
  end

  always_comb begin
    rdData = '0;
    case (regSel)
      2'd0: rdData = ioPkg::wordT'(dataQ);
      2'd1: begin
        rdData[ioPkg::readyBit]   = ready;
        rdData[ioPkg::overrunBit] = overrun;
      end
      default: rdData = '0;
    endcase
  end

endmodule

// ==== ioTimer.sv ====
`timescale 1ns/1ns

module ioTimer (
  input  logic        clk,
  input  logic        reset,
  input  logic        strobe,
  input  logic        write,
  input  logic [1:0]  regSel,
  input  ioPkg::wordT wrData,
  output ioPkg::wordT rdData
);

  logic [$clog2(ioPkg::timerTickDiv)-1:0] preCnt;
  ioPkg::wordT cnt;
  ioPkg::wordT lim;
  logic ready;
  logic overrun;
  logic tick;
  logic atLim;
  logic wrCnt;
  logic wrLim;
  logic wrCtl;

  assign wrCnt = strobe && write && (regSel == 2'd0);
  assign wrLim = strobe && write && (regSel == 2'd1);
  assign wrCtl = strobe && write && (regSel == 2'd2);

  // Prescaler, one tick per timerTickDiv cycles
  assign tick = (preCnt == ioPkg::timerTickDiv - 1);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      preCnt <= '0;
    end else if (tick) begin
      preCnt <= '0;
    end else begin
      preCnt <= preCnt + 1'b1;
    end
  end

  // Zero limit means free counting with no wrap
  assign atLim = (lim != '0) && (cnt == lim - 1'b1);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cnt     <= '0;
      lim     <= '0;
      ready   <= 1'b0;
      overrun <= 1'b0;
    end else if (wrCnt) begin
      cnt     <= wrData;
      ready   <= 1'b0;
      overrun <= 1'b0;
    end else if (wrLim) begin
      lim <= wrData;
      cnt <= '0;
    end else begin
      // Only zeros clear flags, ones are ignored
      if (wrCtl && !wrData[ioPkg::readyBit])   ready   <= 1'b0;
      if (wrCtl && !wrData[ioPkg::overrunBit]) overrun <= 1'b0;
      if (tick) begin
        if (atLim) begin
          cnt <= '0;
          if (ready) overrun <= 1'b1;
          else       ready   <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  always_comb begin
    rdData = '0;
    case (regSel)
      2'd0: rdData = cnt;
      2'd1: rdData = lim;
      2'd2: begin
        rdData[ioPkg::readyBit]   = ready;
        rdData[ioPkg::overrunBit] = overrun;
      end
      default: rdData = '0;
    endcase
  end

endmodule

// ==== displayRegs.sv ====
`timescale 1ns/1ns

module displayRegs (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      hexSel,
  input  logic                      ledSel,
  input  logic                      write,
  input  ioPkg::wordT               wrData,
  output ioPkg::wordT               hexRd,
  output ioPkg::wordT               ledRd,
  output ioPkg::hexOutT             hex,
  output logic [ioPkg::ledBits-1:0] ledr
);

  logic [ioPkg::hexBits-1:0] hexQ;

  // Nibble to active-low segments, bit 6 is segment g
  function automatic ioPkg::segT segDecode(input logic [3:0] nib);
    case (nib)
      4'h0: segDecode = 7'b1000000;
      4'h1: segDecode = 7'b1111001;
      4'h2: segDecode = 7'b0100100;
      4'h3: segDecode = 7'b0110000;
      4'h4: segDecode = 7'b0011001;
      4'h5: segDecode = 7'b0010010;
      4'h6: segDecode = 7'b0000010;
      4'h7: segDecode = 7'b1111000;
      4'h8: segDecode = 7'b0000000;
      4'h9: segDecode = 7'b0010000;
      4'hA: segDecode = 7'b0001000;
      4'hB: segDecode = 7'b0000011;
      4'hC: segDecode = 7'b1000110;
      4'hD: segDecode = 7'b0100001;
      4'hE: segDecode = 7'b0000110;
      default: segDecode = 7'b0001110;
    endcase
  endfunction

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hexQ <= ioPkg::hexResetValue;
      ledr <= '0;
    end else begin
      if (hexSel && write) hexQ <= wrData[ioPkg::hexBits-1:0];
      if (ledSel && write) ledr <= wrData[ioPkg::ledBits-1:0];
    end
  end

  assign hexRd = ioPkg::wordT'(hexQ);
  assign ledRd = ioPkg::wordT'(ledr);

  // Digit i shows nibble i
  always_comb begin
    for (int i = 0; i < ioPkg::hexBits / 4; i++) begin
      hex[i] = segDecode(hexQ[4*i +: 4]);
    end
  end

endmodule

// ==== ioTop.sv ====
`timescale 1ns/1ns

module ioTop (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          req,
  input  ioPkg::busReqT                 busReq,
  output logic                          ack,
  output ioPkg::wordT                   rdData,
  input  logic [ioPkg::keyCount-1:0]    keys,
  input  logic [ioPkg::switchCount-1:0] switches,
  output ioPkg::hexOutT                 hex,
  output logic [ioPkg::ledBits-1:0]     ledr
);

  logic        accWrite;
  ioPkg::wordT accData;
  logic        hexSel;
  logic        ledSel;
  logic        keySel;
  logic        swSel;
  logic        timerSel;
  logic [1:0]  regSel;
  ioPkg::wordT hexRd;
  ioPkg::wordT ledRd;
  ioPkg::wordT keyRd;
  ioPkg::wordT swRd;
  ioPkg::wordT timerRd;

  ioBus busSlave (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .busReq   (busReq),
    .ack      (ack),
    .rdData   (rdData),
    .accWrite (accWrite),
    .accData  (accData),
    .hexSel   (hexSel),
    .ledSel   (ledSel),
    .keySel   (keySel),
    .swSel    (swSel),
    .timerSel (timerSel),
    .regSel   (regSel),
    .hexRd    (hexRd),
    .ledRd    (ledRd),
    .keyRd    (keyRd),
    .swRd     (swRd),
    .timerRd  (timerRd)
  );

  // Keys are active low, the port sees a pressed key as 1
  inputPort #(.rawT(logic [ioPkg::keyCount-1:0])) keyPort (
    .clk    (clk),
    .reset  (reset),
    .raw    (~keys),
    .strobe (keySel),
    .write  (accWrite),
    .regSel (regSel),
    .wrData (accData),
    .rdData (keyRd)
  );

  inputPort #(.rawT(logic [ioPkg::switchCount-1:0])) switchPort (
    .clk    (clk),
    .reset  (reset),
    .raw    (switches),
    .strobe (swSel),
    .write  (accWrite),
    .regSel (regSel),
    .wrData (accData),
    .rdData (swRd)
  );

  ioTimer timer (
    .clk    (clk),
    .reset  (reset),
    .strobe (timerSel),
    .write  (accWrite),
    .regSel (regSel),
    .wrData (accData),
    .rdData (timerRd)
  );

  displayRegs display (
    .clk    (clk),
    .reset  (reset),
    .hexSel (hexSel),
    .ledSel (ledSel),
    .write  (accWrite),
    .wrData (accData),
    .hexRd  (hexRd),
    .ledRd  (ledRd),
    .hex    (hex),
    .ledr   (ledr)
  );

endmodule

// ==== ioTopTb.sv ====
`timescale 1ns/1ns

module ioTopTb;

  typedef enum logic [3:0] {
    opWrite, opRead, opRange, opHold, opKeys, opSwitches, opWait, opDisp, opPoll
  } opT;

  // For opRange the data field holds the low bound
  // For opPoll it holds the flag mask
  typedef struct packed {
    opT          op;
    ioPkg::wordT addr;
    ioPkg::wordT data;
    ioPkg::wordT expected;
  } stepT;

  localparam int clkPeriod   = 40;
  localparam int resetCycles = 10;
  localparam int ackLimit    = 8;
  localparam int pollLimit   = 4 * ioPkg::timerTickDiv;
  localparam int stepBudget  = ioPkg::debounceCycles + 4 * ioPkg::timerTickDiv + 20;
  localparam int holdCycles  = 5 * ioPkg::timerTickDiv;
  localparam ioPkg::wordT readyMask   = 32'd1 << ioPkg::readyBit;
  localparam ioPkg::wordT overrunMask = 32'd1 << ioPkg::overrunBit;
  localparam logic [ioPkg::keyCount-1:0] keysFirst  = 4'b1110;
  localparam logic [ioPkg::keyCount-1:0] keysSecond = 4'b1100;
  localparam logic [ioPkg::switchCount-1:0] switchVal = 10'h2A5;

  logic                          clk;
  logic                          reset;
  logic                          req;
  ioPkg::busReqT                 busReq;
  logic                          ack;
  ioPkg::wordT                   rdData;
  logic [ioPkg::keyCount-1:0]    keys;
  logic [ioPkg::switchCount-1:0] switches;
  ioPkg::hexOutT                 hex;
  logic [ioPkg::ledBits-1:0]     ledr;
  stepT                          steps[$];
  integer                        seed = 32'h0acdbeb6;
  logic                          tableReady = 1'b0;

  ioTop u_dut (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .busReq   (busReq),
    .ack      (ack),
    .rdData   (rdData),
    .keys     (keys),
    .switches (switches),
    .hex      (hex),
    .ledr     (ledr)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // Lit segments gfedcba per digit are inverted for the active-low display
  function automatic ioPkg::hexOutT expectHex(input logic [ioPkg::hexBits-1:0] value);
    ioPkg::hexOutT segs;
    logic [6:0] lit;
    for (int i = 0; i < ioPkg::hexBits / 4; i++) begin
      case (value[4*i +: 4])
        4'h0: lit = 7'h3F;
        4'h1: lit = 7'h06;
        4'h2: lit = 7'h5B;
        4'h3: lit = 7'h4F;
        4'h4: lit = 7'h66;
        4'h5: lit = 7'h6D;
        4'h6: lit = 7'h7D;
        4'h7: lit = 7'h07;
        4'h8: lit = 7'h7F;
        4'h9: lit = 7'h6F;
        4'hA: lit = 7'h77;
        4'hB: lit = 7'h7C;
        4'hC: lit = 7'h39;
        4'hD: lit = 7'h5E;
        4'hE: lit = 7'h79;
        default: lit = 7'h71;
      endcase
      segs[i] = ~lit;
    end
    return segs;
  endfunction

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic checkWord(input string what, input ioPkg::wordT got, input ioPkg::wordT exp);
    if (got !== exp)
      failRun($sformatf("ERROR at %0t ns: %s gave %h, expected %h", $time, what, got, exp));
  endtask

  task automatic checkRange(input string what, input ioPkg::wordT got,
                            input ioPkg::wordT lo, input ioPkg::wordT hi);
    if (got < lo || got > hi)
      failRun($sformatf("ERROR at %0t ns: %s gave %0d, expected %0d to %0d",
                        $time, what, got, lo, hi));
  endtask

  task automatic checkHex(input ioPkg::hexOutT got, input ioPkg::hexOutT exp);
    if (got !== exp)
      failRun($sformatf("ERROR at %0t ns: hex segments %h, expected %h", $time, got, exp));
  endtask

  task automatic checkLeds(input logic [ioPkg::ledBits-1:0] got,
                           input logic [ioPkg::ledBits-1:0] exp);
    if (got !== exp)
      failRun($sformatf("ERROR at %0t ns: ledr %h, expected %h", $time, got, exp));
  endtask

  // One four-phase access with req optionally held high after ack
  task automatic busAccess(input ioPkg::wordT addr, input ioPkg::wordT data, input logic write,
                           input int hold, output ioPkg::wordT rdVal);
    int waited;
    @(negedge clk);
    busReq.addr  = addr;
    busReq.data  = data;
    busReq.write = write;
    req          = 1'b1;
    waited       = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > ackLimit) failRun("The DUT never raised ack for a request");
    end while (!ack);
    rdVal = rdData;
    repeat (hold) @(negedge clk);
    req    = 1'b0;
    waited = 0;
    while (ack) begin
      @(negedge clk);
      waited++;
      if (waited > ackLimit) failRun("The DUT kept ack high after req fell");
    end
  endtask

  function automatic void addStep(opT op, ioPkg::wordT addr, ioPkg::wordT data,
                                  ioPkg::wordT expected);
    stepT s;
    s.op       = op;
    s.addr     = addr;
    s.data     = data;
    s.expected = expected;
    steps.push_back(s);
  endfunction

  function automatic void buildTable();
    ioPkg::wordT rndHex;
    ioPkg::wordT rndLed;
    // Reset state including an unmapped address
    addStep(opDisp, '0, ioPkg::hexResetValue, '0);
    addStep(opRead, ioPkg::addrKeyCtrl, '0, '0);
    addStep(opRead, ioPkg::addrSwCtrl, '0, '0);
    addStep(opRead, ioPkg::addrTimerCtl, '0, '0);
    addStep(opRead, ioPkg::addrTimerLim, '0, '0);
    addStep(opRead, ioPkg::addrKeyData, '0, '0);
    addStep(opRead, ioPkg::addrSwData, '0, '0);
    addStep(opRead, 32'hFFFF_F200, '0, '0);
    repeat (2) begin
      rndHex = $random(seed);
      rndLed = $random(seed);
      addStep(opWrite, ioPkg::addrHex, rndHex, '0);
      addStep(opWrite, ioPkg::addrLedr, rndLed, '0);
      addStep(opDisp, '0, rndHex, rndLed);
      addStep(opRead, ioPkg::addrHex, '0, rndHex & ((32'd1 << ioPkg::hexBits) - 1));
      addStep(opRead, ioPkg::addrLedr, '0, rndLed & ((32'd1 << ioPkg::ledBits) - 1));
    end
    addStep(opSwitches, '0, switchVal, '0);
    addStep(opWait, '0, ioPkg::debounceCycles + 4, '0);
    addStep(opRead, ioPkg::addrSwCtrl, '0, readyMask);
    addStep(opRead, ioPkg::addrSwData, '0, switchVal);
    addStep(opRead, ioPkg::addrSwCtrl, '0, '0);
    // Second key change lands before the first one is read
    addStep(opKeys, '0, keysFirst, '0);
    addStep(opWait, '0, ioPkg::debounceCycles + 4, '0);
    addStep(opKeys, '0, keysSecond, '0);
    addStep(opWait, '0, ioPkg::debounceCycles + 4, '0);
    addStep(opRead, ioPkg::addrKeyCtrl, '0, readyMask | overrunMask);
    addStep(opRead, ioPkg::addrKeyData, '0, {{(32 - ioPkg::keyCount){1'b0}}, ~keysSecond});
    addStep(opRead, ioPkg::addrKeyCtrl, '0, overrunMask);
    addStep(opWrite, ioPkg::addrKeyCtrl, '0, '0);
    addStep(opRead, ioPkg::addrKeyCtrl, '0, '0);
    addStep(opWrite, ioPkg::addrTimerLim, 32'd3, '0);
    addStep(opRange, ioPkg::addrTimerCnt, 32'd0, 32'd2);
    addStep(opPoll, ioPkg::addrTimerCtl, readyMask, readyMask);
    addStep(opRange, ioPkg::addrTimerCnt, 32'd0, 32'd2);
    // Stop wrapping before clearing so no new flag races the read
    addStep(opWrite, ioPkg::addrTimerLim, '0, '0);
    addStep(opWrite, ioPkg::addrTimerCtl, '0, '0);
    addStep(opRead, ioPkg::addrTimerCtl, '0, '0);
    // The held req lasts about one tick per timerTickDiv cycles
    // A repeated write would pull the count back
    addStep(opHold, ioPkg::addrTimerCnt, 32'd100, holdCycles);
    addStep(opRange, ioPkg::addrTimerCnt, 32'd100 + holdCycles / ioPkg::timerTickDiv - 1,
            32'd100 + holdCycles / ioPkg::timerTickDiv + 3);
    addStep(opRead, ioPkg::addrTimerLim, '0, '0);
  endfunction

  initial begin
    ioPkg::wordT rdVal;
    int pollCount;
    logic pollDone;
    req      = 1'b0;
    busReq   = '0;
    keys     = '1;
    switches = '0;
    reset    = 1'b1;
    buildTable();
    tableReady = 1'b1;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    foreach (steps[i]) begin
      case (steps[i].op)
        opWrite: busAccess(steps[i].addr, steps[i].data, 1'b1, 0, rdVal);
        opHold:  busAccess(steps[i].addr, steps[i].data, 1'b1, steps[i].expected, rdVal);
        opRead: begin
          busAccess(steps[i].addr, '0, 1'b0, 0, rdVal);
          checkWord($sformatf("read of %h", steps[i].addr), rdVal, steps[i].expected);
        end
        opRange: begin
          busAccess(steps[i].addr, '0, 1'b0, 0, rdVal);
          checkRange($sformatf("read of %h", steps[i].addr), rdVal, steps[i].data,
                     steps[i].expected);
        end
        opKeys: begin
          @(negedge clk);
          keys = steps[i].data[ioPkg::keyCount-1:0];
        end
        opSwitches: begin
          @(negedge clk);
          switches = steps[i].data[ioPkg::switchCount-1:0];
        end
        opWait: repeat (steps[i].data) @(negedge clk);
        opDisp: begin
          @(negedge clk);
          checkHex(hex, expectHex(steps[i].data[ioPkg::hexBits-1:0]));
          checkLeds(ledr, steps[i].expected[ioPkg::ledBits-1:0]);
        end
        default: begin
          pollCount = 0;
          pollDone  = 1'b0;
          while (!pollDone && pollCount < pollLimit) begin
            busAccess(steps[i].addr, '0, 1'b0, 0, rdVal);
            pollDone = ((rdVal & steps[i].data) == steps[i].expected);
            pollCount++;
          end
          if (!pollDone)
            failRun($sformatf("ERROR at %0t ns: flag %h at %h not seen after %0d reads",
                              $time, steps[i].data, steps[i].addr, pollLimit));
        end
      endcase
    end
    $display("Test OK");
    $finish;
  end

  // Budget grows with the table length
  initial begin
    wait (tableReady);
    #((steps.size() * stepBudget + resetCycles) * clkPeriod);
    $display("Timeout: the stimulus table did not finish in its time budget");
    $display("Test FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule

// ==== files.f ====
ioPkg.sv
ioBus.sv
inputPort.sv
ioTimer.sv
displayRegs.sv
ioTop.sv
ioTopTb.sv

// ==== Bender.yml ====
package:
  name: io_subsystem

sources:
  - ioPkg.sv
  - ioBus.sv
  - inputPort.sv
  - ioTimer.sv
  - displayRegs.sv
  - ioTop.sv
  - target: test
    files:
      - ioTopTb.sv
